// File: Makefile
# Verilator build and run of the board control testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = board_ctrl_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
+incdir+verification
src/reg_map_pkg.sv
src/spi_frame_pkg.sv
src/spi_reg_slave.sv
src/board_regs.sv
src/rx_err_counters.sv
src/status_blink.sv
src/board_ctrl_top.sv
verification/board_ctrl_sva.sv
verification/board_ctrl_tb.sv

// File: src/board_ctrl_top.sv
`timescale 1ns/1ps
// board control top: spi register slave, register file, error counters
// status led, mdio tristate and qspi flash pass-through
module board_ctrl_top #(
    parameter logic [31:0] fw_date       = 32'h5A3C_96E1,
    parameter logic [31:0] fw_time       = 32'h0F1E_2D3C,
    parameter int          clk_per_ms    = 125000,
    parameter int          blink_half_ms = 250
) (
    input  logic                             reg_clk,
    input  logic                             rst_n_i,
    input  logic                             spi_clk_i,
    input  logic [1:0]                       spi_cs_i,      // 0 flash, 1 registers
    input  logic                             spi_mosi_i,
    output logic                             spi_miso_o,
    output logic                             qspi_cs_o,
    output logic                             qspi_io0_o,
    input  logic                             qspi_io1_i,
    output logic                             qspi_io2_o,
    output logic                             qspi_io3_o,
    input  logic [reg_map_pkg::eth_ports-1:0] mac_link_i,
    input  logic [reg_map_pkg::eth_ports-1:0] rx_err_i,
    output logic [reg_map_pkg::eth_ports-1:0] eth_phy_rst_o,
    output logic                             eth_phy_mdc_o,
    inout  wire                              eth_phy_mdio_io,
    output logic                             dbg_led_o
);

    logic                                 slave_miso;
    logic                                 wr_en;
    logic [reg_map_pkg::reg_awidth-1:0]    wr_addr;
    logic [reg_map_pkg::reg_dwidth-1:0]    wr_data;
    logic [reg_map_pkg::reg_awidth-1:0]    rd_addr;
    logic [reg_map_pkg::reg_dwidth-1:0]    rd_data;
    logic [reg_map_pkg::eth_ports-1:0][reg_map_pkg::cnt_width-1:0] rxerr_cnt;
    logic                                 mdio_dout;
    logic                                 mdio_dir;

    spi_reg_slave u_spi_slave (
        .reg_clk    (reg_clk),
        .rst_n_i    (rst_n_i),
        .spi_clk_i  (spi_clk_i),
        .spi_cs_i   (spi_cs_i[1]),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (slave_miso),
        .rd_data_i  (rd_data),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .rd_addr_o  (rd_addr)
    );

    board_regs #(
        .fw_date (fw_date),
        .fw_time (fw_time)
    ) u_regs (
        .reg_clk     (reg_clk),
        .rst_n_i     (rst_n_i),
        .wr_en_i     (wr_en),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .rd_addr_i   (rd_addr),
        .mac_link_i  (mac_link_i),
        .rxerr_cnt_i (rxerr_cnt),
        .mdio_din_i  (eth_phy_mdio_io),
        .rd_data_o   (rd_data),
        .phy_rst_o   (eth_phy_rst_o),
        .mdio_clk_o  (eth_phy_mdc_o),
        .mdio_dout_o (mdio_dout),
        .mdio_dir_o  (mdio_dir)
    );

    rx_err_counters u_rxerr (
        .reg_clk  (reg_clk),
        .rst_n_i  (rst_n_i),
        .rx_err_i (rx_err_i),
        .cnt_o    (rxerr_cnt)
    );

    status_blink #(
        .clk_per_ms    (clk_per_ms),
        .blink_half_ms (blink_half_ms)
    ) u_blink (
        .reg_clk (reg_clk),
        .rst_n_i (rst_n_i),
        .led_o   (dbg_led_o)
    );

    // ----------------------------
    // pins
    // ----------------------------
    assign eth_phy_mdio_io = mdio_dir ? mdio_dout : 1'bz;   // released when dir is 0

    assign qspi_cs_o  = spi_cs_i[0];
    assign qspi_io0_o = spi_mosi_i;
    assign qspi_io2_o = 1'b1;   // wp and hold inactive
    assign qspi_io3_o = 1'b1;
    // deselected side reads as 1, so the and picks the active one
    assign spi_miso_o = (qspi_io1_i | spi_cs_i[0]) & (slave_miso | spi_cs_i[1]);

endmodule

// File: src/board_regs.sv
`timescale 1ns/1ps
// board register file: write decode, read mux over the full map
// phy reset, mdio bit-bang and test registers
module board_regs #(
    parameter logic [31:0] fw_date = 32'h0,
    parameter logic [31:0] fw_time = 32'h0
) (
    input  logic                                 reg_clk,
    input  logic                                 rst_n_i,
    input  logic                                 wr_en_i,
    input  logic [reg_map_pkg::reg_awidth-1:0]    wr_addr_i,
    input  logic [reg_map_pkg::reg_dwidth-1:0]    wr_data_i,
    input  logic [reg_map_pkg::reg_awidth-1:0]    rd_addr_i,
    input  logic [reg_map_pkg::eth_ports-1:0]     mac_link_i,
    input  logic [reg_map_pkg::eth_ports-1:0][reg_map_pkg::cnt_width-1:0] rxerr_cnt_i,
    input  logic                                 mdio_din_i,
    output logic [reg_map_pkg::reg_dwidth-1:0]    rd_data_o,
    output logic [reg_map_pkg::eth_ports-1:0]     phy_rst_o,
    output logic                                 mdio_clk_o,
    output logic                                 mdio_dout_o,
    output logic                                 mdio_dir_o
);

    localparam int dw    = reg_map_pkg::reg_dwidth;
    localparam int aw    = reg_map_pkg::reg_awidth;
    localparam int idx_w = $clog2(reg_map_pkg::test_array_count);
    localparam int prt_w = $clog2(reg_map_pkg::eth_ports);

    logic [dw-1:0] test_array [reg_map_pkg::test_array_count];
    logic [1:0]    mdio_sync;       // 2-flop input sync
    logic [aw-1:0] test_wr_off;
    logic [aw-1:0] test_rd_off;
    logic [aw-1:0] rx_off;
    logic          test_wr_hit;

    assign test_wr_off = wr_addr_i - reg_map_pkg::reg_test_base;
    assign test_rd_off = rd_addr_i - reg_map_pkg::reg_test_base;
    assign rx_off      = rd_addr_i - reg_map_pkg::rreg_rxerr_base;
    assign test_wr_hit = (wr_addr_i >= reg_map_pkg::reg_test_base) &&
                         (wr_addr_i <= reg_map_pkg::reg_test_last);

    // ----------------------------
    // write decode
    // ----------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phy_rst_o   <= reg_map_pkg::phy_rst_init;
            mdio_clk_o  <= reg_map_pkg::mdio_init;
            mdio_dout_o <= reg_map_pkg::mdio_init;
            mdio_dir_o  <= reg_map_pkg::mdio_init;
            for (int i = 0; i < reg_map_pkg::test_array_count; i++) begin
                test_array[i] <= reg_map_pkg::test_init;
            end
        end else if (wr_en_i) begin
            case (wr_addr_i)
                reg_map_pkg::reg_phy_rst:   phy_rst_o   <= wr_data_i[reg_map_pkg::eth_ports-1:0];
                reg_map_pkg::reg_mdio_clk:  mdio_clk_o  <= wr_data_i[0];
                reg_map_pkg::reg_mdio_dout: mdio_dout_o <= wr_data_i[0];
                reg_map_pkg::reg_mdio_dir:  mdio_dir_o  <= wr_data_i[0];
                default: begin
                    if (test_wr_hit) begin
                        test_array[test_wr_off[idx_w-1:0]] <= wr_data_i;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mdio_sync <= '0;
        end else begin
            mdio_sync <= {mdio_sync[0], mdio_din_i};
        end
    end

    // ----------------------------
    // read mux, unmapped reads give 0
    // ----------------------------
    always_comb begin
        rd_data_o = '0;
        case (rd_addr_i)
            reg_map_pkg::rreg_fw_date:         rd_data_o = fw_date[0 +: dw];
            reg_map_pkg::rreg_fw_date + 7'd1:  rd_data_o = fw_date[dw +: dw];
            reg_map_pkg::rreg_fw_time:         rd_data_o = fw_time[0 +: dw];
            reg_map_pkg::rreg_fw_time + 7'd1:  rd_data_o = fw_time[dw +: dw];
            reg_map_pkg::rreg_fw_type:         rd_data_o = reg_map_pkg::fw_type_code;
            reg_map_pkg::rreg_mac_link:        rd_data_o[reg_map_pkg::eth_ports-1:0] = mac_link_i;
            reg_map_pkg::reg_phy_rst:          rd_data_o[reg_map_pkg::eth_ports-1:0] = phy_rst_o;
            reg_map_pkg::reg_mdio_clk:         rd_data_o[0] = mdio_clk_o;
            reg_map_pkg::reg_mdio_dout:        rd_data_o[0] = mdio_dout_o;
            reg_map_pkg::reg_mdio_dir:         rd_data_o[0] = mdio_dir_o;
            reg_map_pkg::rreg_mdio_din:        rd_data_o[0] = mdio_sync[1];
            default: begin
                if (rd_addr_i >= reg_map_pkg::rreg_rxerr_base &&
                    rd_addr_i <= reg_map_pkg::rreg_rxerr_last) begin
                    // odd offset is the high word
                    rd_data_o = rxerr_cnt_i[rx_off[prt_w:1]][rx_off[0]*dw +: dw];
                end else if (rd_addr_i >= reg_map_pkg::reg_test_base &&
                             rd_addr_i <= reg_map_pkg::reg_test_last) begin
                    rd_data_o = test_array[test_rd_off[idx_w-1:0]];
                end
            end
        endcase
    end

endmodule

// File: src/reg_map_pkg.sv
// register map of the board control block
// widths, address map, firmware type code and reset values
package reg_map_pkg;

    // ----------------------------
    // widths
    // ----------------------------
    localparam int reg_dwidth       = 16;
    localparam int reg_awidth       = 7;
    localparam int eth_ports        = 4;
    localparam int cnt_width        = 32;   // rx crc error counter
    localparam int test_array_count = 8;

    // ----------------------------
    // address map
    // ----------------------------
    localparam logic [reg_awidth-1:0] rreg_fw_date    = 7'h00;  // low word, high at +1
    localparam logic [reg_awidth-1:0] rreg_fw_time    = 7'h02;  // low word, high at +1
    localparam logic [reg_awidth-1:0] rreg_fw_type    = 7'h04;
    localparam logic [reg_awidth-1:0] rreg_mac_link   = 7'h05;  // bits 3..0
    localparam logic [reg_awidth-1:0] reg_phy_rst     = 7'h06;  // bits 3..0, low holds phy
    localparam logic [reg_awidth-1:0] reg_mdio_clk    = 7'h07;
    localparam logic [reg_awidth-1:0] reg_mdio_dout   = 7'h08;
    localparam logic [reg_awidth-1:0] reg_mdio_dir    = 7'h09;  // 1 drives the pin
    localparam logic [reg_awidth-1:0] rreg_mdio_din   = 7'h0A;
    localparam logic [reg_awidth-1:0] rreg_rxerr_base = 7'h0B;  // port n at base+2n
    localparam logic [reg_awidth-1:0] rreg_rxerr_last = 7'h12;
    localparam logic [reg_awidth-1:0] reg_test_base   = 7'h20;
    localparam logic [reg_awidth-1:0] reg_test_last   = 7'h27;  // base + count - 1

    localparam logic [reg_dwidth-1:0] fw_type_code = 16'h0001;

    // ----------------------------
    // reset values
    // ----------------------------
    localparam logic [eth_ports-1:0]  phy_rst_init = '0;    // all phys held in reset
    localparam logic                  mdio_init    = 1'b0;  // mdc low, pin released
    localparam logic [reg_dwidth-1:0] test_init    = '0;

endpackage

// File: src/rx_err_counters.sv
`timescale 1ns/1ps
// receive crc error counters, one saturating counter per port
module rx_err_counters (
    input  logic                                 reg_clk,
    input  logic                                 rst_n_i,
    input  logic [reg_map_pkg::eth_ports-1:0]     rx_err_i,
    output logic [reg_map_pkg::eth_ports-1:0][reg_map_pkg::cnt_width-1:0] cnt_o
);

    localparam int cw = reg_map_pkg::cnt_width;

    logic [cw-1:0] cnt_q [reg_map_pkg::eth_ports];

    genvar n;
    generate
        for (n = 0; n < reg_map_pkg::eth_ports; n++) begin : g_port
            always_ff @(posedge reg_clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    cnt_q[n] <= '0;
                end else if (rx_err_i[n] && cnt_q[n] != '1) begin
                    cnt_q[n] <= cnt_q[n] + 1'b1;    // stops at all ones
                end
            end

            assign cnt_o[n] = cnt_q[n];
        end
    endgenerate

endmodule

// File: src/spi_frame_pkg.sv
// spi frame layout of the register slave
// frame length, field positions and synchronizer depth
package spi_frame_pkg;

    localparam int frame_bits  = 24;
    localparam int cmd_bits    = 8;     // read flag + address

    // field positions inside the frame
    localparam int rd_flag_pos = 23;
    localparam int addr_msb    = 22;
    localparam int addr_lsb    = 16;

    localparam int sync_stages = 2;     // sclk, cs and mosi

endpackage

// File: src/spi_reg_slave.sv
`timescale 1ns/1ps
// spi mode 0 register slave, oversampled in reg_clk
// frame: read flag, 7-bit address, 16-bit data, msb first
module spi_reg_slave (
    input  logic                              reg_clk,
    input  logic                              rst_n_i,
    input  logic                              spi_clk_i,
    input  logic                              spi_cs_i,
    input  logic                              spi_mosi_i,
    output logic                              spi_miso_o,
    input  logic [reg_map_pkg::reg_dwidth-1:0] rd_data_i,
    output logic                              wr_en_o,
    output logic [reg_map_pkg::reg_awidth-1:0] wr_addr_o,
    output logic [reg_map_pkg::reg_dwidth-1:0] wr_data_o,
    output logic [reg_map_pkg::reg_awidth-1:0] rd_addr_o
);

    localparam int ss    = spi_frame_pkg::sync_stages;
    localparam int fbits = spi_frame_pkg::frame_bits;
    localparam int cnt_w = $clog2(fbits + 1);
    localparam int dw    = reg_map_pkg::reg_dwidth;
    // address msb once only the command byte is in
    localparam int cmd_addr_msb = spi_frame_pkg::addr_msb - (fbits - spi_frame_pkg::cmd_bits);
    localparam logic [cnt_w-1:0] cmd_last  = cnt_w'(spi_frame_pkg::cmd_bits - 1);
    localparam logic [cnt_w-1:0] cmd_end   = cnt_w'(spi_frame_pkg::cmd_bits);
    localparam logic [cnt_w-1:0] frame_last = cnt_w'(fbits - 1);
    localparam logic [cnt_w-1:0] frame_end  = cnt_w'(fbits);

    logic [ss-1:0]    sclk_sync;
    logic [ss-1:0]    cs_sync;
    logic [ss-1:0]    mosi_sync;
    logic             sclk_d;
    logic             sclk_rise;
    logic             sclk_fall;
    logic             cs_idle;
    logic [cnt_w-1:0] bit_cnt;
    logic [fbits-1:0] shift_q;
    logic [dw-1:0]    tx_q;
    logic             cmd_done;
    logic             frame_done;
    logic             wr_req;

    // ----------------------------
    // input synchronizers
    // ----------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sclk_sync <= '0;
            cs_sync   <= '1;    // deselected
            mosi_sync <= '0;
            sclk_d    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[ss-2:0], spi_clk_i};
            cs_sync   <= {cs_sync[ss-2:0], spi_cs_i};
            mosi_sync <= {mosi_sync[ss-2:0], spi_mosi_i};
            sclk_d    <= sclk_sync[ss-1];
        end
    end

    assign sclk_rise = sclk_sync[ss-1] & ~sclk_d;
    assign sclk_fall = ~sclk_sync[ss-1] & sclk_d;
    assign cs_idle   = cs_sync[ss-1];

    // ----------------------------
    // bit counter and frame shifter
    // ----------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt    <= '0;
            cmd_done   <= 1'b0;
            frame_done <= 1'b0;
        end else if (cs_idle) begin
            bit_cnt    <= '0;   // drops a cut frame
            cmd_done   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            cmd_done   <= sclk_rise && (bit_cnt == cmd_last);
            frame_done <= sclk_rise && (bit_cnt == frame_last);
            if (sclk_rise && bit_cnt != frame_end) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!cs_idle && sclk_rise) begin
            shift_q <= {shift_q[fbits-2:0], mosi_sync[ss-1]};
        end
    end

    assign rd_addr_o = shift_q[cmd_addr_msb -: reg_map_pkg::reg_awidth];

    // ----------------------------
    // write strobe, 3 cycles after the last rise
    // ----------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_req  <= 1'b0;
            wr_en_o <= 1'b0;
        end else begin
            wr_req  <= frame_done & ~shift_q[spi_frame_pkg::rd_flag_pos] & ~cs_idle;
            wr_en_o <= wr_req;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (frame_done) begin
            wr_addr_o <= shift_q[spi_frame_pkg::addr_msb:spi_frame_pkg::addr_lsb];
            wr_data_o <= shift_q[dw-1:0];
        end
    end

    // read word goes out on falling edges
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_q       <= '0;
            spi_miso_o <= 1'b0;
        end else if (cs_idle) begin
            tx_q       <= '0;
            spi_miso_o <= 1'b0;
        end else if (cmd_done) begin
            tx_q <= shift_q[spi_frame_pkg::cmd_bits-1] ? rd_data_i : '0;    // read flag
        end else if (sclk_fall && bit_cnt >= cmd_end) begin
            spi_miso_o <= tx_q[dw-1];
            tx_q       <= {tx_q[dw-2:0], 1'b0};
        end
    end

endmodule

// File: src/status_blink.sv
`timescale 1ns/1ps
// status led blinker
// millisecond prescaler, half-period ms count, led toggle
module status_blink #(
    parameter int clk_per_ms    = 125000,
    parameter int blink_half_ms = 250
) (
    input  logic reg_clk,
    input  logic rst_n_i,
    output logic led_o
);

    localparam int pre_w = $clog2(clk_per_ms + 1);
    localparam int ms_w  = $clog2(blink_half_ms + 1);
    localparam logic [pre_w-1:0] pre_last = pre_w'(clk_per_ms - 1);
    localparam logic [ms_w-1:0]  ms_last  = ms_w'(blink_half_ms - 1);

    logic [pre_w-1:0] pre_cnt;
    logic [ms_w-1:0]  ms_cnt;
    logic             ms_tick;

    // ----------------------------
    // prescaler
    // ----------------------------
    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pre_cnt <= '0;
            ms_tick <= 1'b0;
        end else if (pre_cnt == pre_last) begin
            pre_cnt <= '0;
            ms_tick <= 1'b1;    // one pulse per ms
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            ms_tick <= 1'b0;
        end
    end

    always_ff @(posedge reg_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ms_cnt <= '0;
            led_o  <= 1'b0;
        end else if (ms_tick) begin
            if (ms_cnt == ms_last) begin
                ms_cnt <= '0;
                led_o  <= ~led_o;   // half period done
            end else begin
                ms_cnt <= ms_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verification/board_ctrl_sva.sv
`timescale 1ns/1ps
// assertions on the spi register slave, bound into every instance
module board_ctrl_sva (
    input logic reg_clk,
    input logic rst_n_i,
    input logic sclk_i,
    input logic miso_i,
    input logic wr_en_i,
    input logic cs_idle_i
);

    // write strobe lasts one cycle
    wr_single_pulse: assert property (@(posedge reg_clk) disable iff (!rst_n_i)
        wr_en_i |=> !wr_en_i)
        else $error("register write strobe held for more than one cycle");

    // deselected slave never writes
    wr_needs_select: assert property (@(posedge reg_clk) disable iff (!rst_n_i)
        cs_idle_i |-> !wr_en_i)
        else $error("register write while chip select is high");

    // host samples on the high phase
    miso_stable_high: assert property (@(posedge reg_clk) disable iff (!rst_n_i)
        sclk_i && $past(sclk_i) |-> $stable(miso_i))
        else $error("slave MISO changed while SCLK was high");

endmodule

bind spi_reg_slave board_ctrl_sva u_slave_sva (
    .reg_clk   (reg_clk),
    .rst_n_i   (rst_n_i),
    .sclk_i    (spi_clk_i),
    .miso_i    (spi_miso_o),
    .wr_en_i   (wr_en_o),
    .cs_idle_i (cs_idle)
);

// File: verification/board_ctrl_tests.svh
// spi bus tasks and directed tests of the board control block
// included into the testbench module

// ------------------------------
// spi bus
// ------------------------------
task automatic spi_transfer(input logic [23:0] frame, input int n_bits,
                            output logic [15:0] rx_word);
    rx_word     = '0;
    spi_cs_i[1] = 1'b0;
    wait_clocks(half_clk);
    for (int i = 0; i < n_bits; i++) begin
        spi_mosi_i = frame[spi_frame_pkg::frame_bits - 1 - i];    // msb first
        wait_clocks(half_clk);
        spi_clk_i = 1'b1;
        if (i >= spi_frame_pkg::cmd_bits) begin
            rx_word = {rx_word[14:0], spi_miso_o};
        end
        wait_clocks(half_clk);
        spi_clk_i = 1'b0;
    end
    wait_clocks(half_clk);
    spi_cs_i[1] = 1'b1;     // a short frame ends here too
    wait_clocks(half_clk);
endtask

task automatic reg_write(input logic [6:0] addr, input logic [15:0] data);
    logic [15:0] unused_rx;
    spi_transfer({1'b0, addr, data}, spi_frame_pkg::frame_bits, unused_rx);
endtask

task automatic reg_read(input logic [6:0] addr, output logic [15:0] data);
    spi_transfer({1'b1, addr, 16'h0000}, spi_frame_pkg::frame_bits, data);
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic reset_state();
    logic [15:0] rd;
    start_case("reset_state");
    check_value("phy reset pins", 32'h0, 32'(eth_phy_rst_o));
    check_value("mdc pin", 32'h0, 32'(eth_phy_mdc_o));
    check_value("led", 32'h0, 32'(dbg_led_o));
    // released pin follows the phy side only
    mdio_drive_en  = 1'b1;
    mdio_drive_val = 1'b1;
    wait_clocks(1);
    check_value("mdio released, phy drives 1", 32'h1, 32'(eth_phy_mdio_io));
    mdio_drive_val = 1'b0;
    wait_clocks(1);
    check_value("mdio released, phy drives 0", 32'h0, 32'(eth_phy_mdio_io));
    mdio_drive_en = 1'b0;
    for (int k = 0; k < 4; k++) begin
        reg_read(7'(reg_map_pkg::reg_phy_rst + k), rd);
        check_value($sformatf("reset value at %0d", reg_map_pkg::reg_phy_rst + k),
                    32'h0, 32'(rd));
    end
    end_case();
endtask

task automatic identity_and_status();
    logic [15:0] rd;
    logic [3:0]  link;
    start_case("identity_and_status");
    reg_read(reg_map_pkg::rreg_fw_date, rd);
    check_value("fw date low", 32'(fw_date[15:0]), 32'(rd));
    reg_read(7'(reg_map_pkg::rreg_fw_date + 1), rd);
    check_value("fw date high", 32'(fw_date[31:16]), 32'(rd));
    reg_read(reg_map_pkg::rreg_fw_time, rd);
    check_value("fw time low", 32'(fw_time[15:0]), 32'(rd));
    reg_read(7'(reg_map_pkg::rreg_fw_time + 1), rd);
    check_value("fw time high", 32'(fw_time[31:16]), 32'(rd));
    reg_read(reg_map_pkg::rreg_fw_type, rd);
    check_value("fw type", 32'(reg_map_pkg::fw_type_code), 32'(rd));
    for (int k = 0; k < 3; k++) begin
        link       = 4'($urandom);
        mac_link_i = link;
        reg_read(reg_map_pkg::rreg_mac_link, rd);
        check_value("link state", 32'(link), 32'(rd));
    end
    end_case();
endtask

task automatic test_regs_and_phy_reset();
    logic [15:0] vals [reg_map_pkg::test_array_count];
    logic [15:0] rd;
    logic [3:0]  phy;
    start_case("test_regs_and_phy_reset");
    for (int i = 0; i < reg_map_pkg::test_array_count; i++) begin
        vals[i] = 16'($urandom);
        reg_write(7'(reg_map_pkg::reg_test_base + i), vals[i]);
    end
    phy = 4'($urandom);
    reg_write(reg_map_pkg::reg_phy_rst, {12'h000, phy});
    for (int i = 0; i < reg_map_pkg::test_array_count; i++) begin
        reg_read(7'(reg_map_pkg::reg_test_base + i), rd);
        check_value($sformatf("test register %0d", i), 32'(vals[i]), 32'(rd));
    end
    reg_read(reg_map_pkg::reg_phy_rst, rd);
    check_value("phy reset readback", 32'(phy), 32'(rd));
    check_value("phy reset pins", 32'(phy), 32'(eth_phy_rst_o));
    // read-only and unmapped writes are dropped
    reg_write(reg_map_pkg::rreg_fw_type, ~reg_map_pkg::fw_type_code);
    reg_read(reg_map_pkg::rreg_fw_type, rd);
    check_value("fw type after write", 32'(reg_map_pkg::fw_type_code), 32'(rd));
    reg_write(7'h30, 16'hBEEF);     // hole in the map
    reg_read(7'h30, rd);
    check_value("unmapped read", 32'h0, 32'(rd));
    // cut after 12 bits, must not land
    spi_transfer({1'b0, reg_map_pkg::reg_test_base, ~vals[0]}, 12, rd);
    reg_read(reg_map_pkg::reg_test_base, rd);
    check_value("test register 0 after short frame", 32'(vals[0]), 32'(rd));
    end_case();
endtask

task automatic mdio_bitbang();
    logic [15:0] rd;
    start_case("mdio_bitbang");
    reg_write(reg_map_pkg::reg_mdio_dout, 16'h0001);
    reg_write(reg_map_pkg::reg_mdio_dir, 16'h0001);
    reg_write(reg_map_pkg::reg_mdio_clk, 16'h0001);
    check_value("mdc high", 32'h1, 32'(eth_phy_mdc_o));
    check_value("mdio driven 1", 32'h1, 32'(eth_phy_mdio_io));
    reg_write(reg_map_pkg::reg_mdio_dout, 16'h0000);
    check_value("mdio driven 0", 32'h0, 32'(eth_phy_mdio_io));
    // clk and dir still 1, dout now 0
    reg_read(reg_map_pkg::reg_mdio_clk, rd);
    check_value("mdc readback", 32'h1, 32'(rd));
    reg_read(reg_map_pkg::reg_mdio_dout, rd);
    check_value("mdio out readback", 32'h0, 32'(rd));
    reg_write(reg_map_pkg::reg_mdio_clk, 16'h0000);
    check_value("mdc low", 32'h0, 32'(eth_phy_mdc_o));
    reg_read(reg_map_pkg::reg_mdio_dir, rd);
    check_value("mdio dir readback", 32'h1, 32'(rd));
    // turn the bus around and let the phy talk
    reg_write(reg_map_pkg::reg_mdio_dir, 16'h0000);
    mdio_drive_en  = 1'b1;
    mdio_drive_val = 1'b1;
    reg_read(reg_map_pkg::rreg_mdio_din, rd);
    check_value("mdio input 1", 32'h1, 32'(rd));
    mdio_drive_val = 1'b0;
    reg_read(reg_map_pkg::rreg_mdio_din, rd);
    check_value("mdio input 0", 32'h0, 32'(rd));
    mdio_drive_en = 1'b0;
    end_case();
endtask

task automatic error_counters();
    int          counts [reg_map_pkg::eth_ports];
    logic [3:0]  pulses;
    logic [15:0] lo;
    logic [15:0] hi;
    start_case("error_counters");
    for (int n = 0; n < reg_map_pkg::eth_ports; n++) begin
        counts[n] = 0;
    end
    for (int c = 0; c < 40; c++) begin
        pulses   = 4'($urandom);
        rx_err_i = pulses;
        for (int n = 0; n < reg_map_pkg::eth_ports; n++) begin
            if (pulses[n]) begin
                counts[n]++;    // one count per high cycle
            end
        end
        wait_clocks(1);
    end
    rx_err_i = 4'h0;
    wait_clocks(2);
    for (int n = 0; n < reg_map_pkg::eth_ports; n++) begin
        reg_read(7'(reg_map_pkg::rreg_rxerr_base + 2 * n), lo);
        reg_read(7'(reg_map_pkg::rreg_rxerr_base + 2 * n + 1), hi);
        check_value($sformatf("rx error count port %0d", n), 32'(counts[n]), {hi, lo});
    end
    end_case();
endtask

task automatic led_toggle_wait(output int cycles);
    logic start;
    start  = dbg_led_o;
    cycles = 0;
    while (dbg_led_o == start && cycles < 100) begin
        wait_clocks(1);
        cycles++;
    end
endtask

task automatic flash_and_led();
    logic mosi_bit;
    logic io1_bit;
    int   gap;
    start_case("flash_and_led");
    spi_cs_i = 2'b10;   // flash selected
    for (int i = 0; i < 8; i++) begin
        mosi_bit   = 1'($urandom);
        io1_bit    = 1'($urandom);
        spi_mosi_i = mosi_bit;
        qspi_io1_i = io1_bit;
        wait_clocks(1);
        check_value("flash cs", 32'h0, 32'(qspi_cs_o));
        check_value("flash io0", 32'(mosi_bit), 32'(qspi_io0_o));
        check_value("host miso from flash", 32'(io1_bit), 32'(spi_miso_o));
    end
    check_value("flash io2", 32'h1, 32'(qspi_io2_o));
    check_value("flash io3", 32'h1, 32'(qspi_io3_o));
    spi_cs_i   = 2'b11;
    qspi_io1_i = 1'b0;
    wait_clocks(1);
    check_value("flash cs released", 32'h1, 32'(qspi_cs_o));
    check_value("host miso idle", 32'h1, 32'(spi_miso_o));
    spi_mosi_i = 1'b0;
    qspi_io1_i = 1'b1;
    // first toggle aligns, second one is timed
    led_toggle_wait(gap);
    if (gap < 100) begin
        led_toggle_wait(gap);
    end
    if (gap >= 100) begin
        $display("%s: the LED did not toggle within 100 cycles", cur_test);
        test_errors++;
        total_errors++;
    end else begin
        check_value("led half period", 32'(clk_per_ms * blink_half_ms), 32'(gap));
    end
    end_case();
endtask

// File: verification/board_ctrl_tb.sv
`timescale 1ns/1ps
// board control testbench: clock, reset, DUT, watchdog and summary
// the directed tests live in board_ctrl_tests.svh
module board_ctrl_tb;

    localparam logic [31:0] fw_date       = 32'hA5C3_1E07;
    localparam logic [31:0] fw_time       = 32'h6B19_D2F0;
    localparam int          clk_per_ms    = 10;
    localparam int          blink_half_ms = 3;
    localparam int          half_clk      = 8;      // sclk half period in reg_clk cycles
    localparam int          reset_cycles  = 16;
    localparam int unsigned seed          = 32'h98c6_f351;

    // ------------------------------
    // watchdog budget
    // ------------------------------
    localparam int total_frames  = 60;  // 55 frames over all tests, rounded up
    localparam int frame_cycles  = spi_frame_pkg::frame_bits * 2 * half_clk + 4 * half_clk;
    localparam int margin_cycles = 3000;    // reset, pulses, led and flash checks
    localparam int watchdog_ns   = (total_frames * frame_cycles + margin_cycles) * 40;

    logic       reg_clk;
    logic       rst_n_i;
    logic       spi_clk_i;
    logic [1:0] spi_cs_i;
    logic       spi_mosi_i;
    logic       spi_miso_o;
    logic       qspi_cs_o;
    logic       qspi_io0_o;
    logic       qspi_io1_i;
    logic       qspi_io2_o;
    logic       qspi_io3_o;
    logic [3:0] mac_link_i;
    logic [3:0] rx_err_i;
    logic [3:0] eth_phy_rst_o;
    logic       eth_phy_mdc_o;
    wire        eth_phy_mdio_io;
    logic       dbg_led_o;
    logic       mdio_drive_en;      // phy side driver
    logic       mdio_drive_val;

    string cur_test;
    int    test_errors;
    int    total_errors;
    int    tests_run;
    int    checks_run;

    board_ctrl_top #(
        .fw_date       (fw_date),
        .fw_time       (fw_time),
        .clk_per_ms    (clk_per_ms),
        .blink_half_ms (blink_half_ms)
    ) uut (
        .reg_clk         (reg_clk),
        .rst_n_i         (rst_n_i),
        .spi_clk_i       (spi_clk_i),
        .spi_cs_i        (spi_cs_i),
        .spi_mosi_i      (spi_mosi_i),
        .spi_miso_o      (spi_miso_o),
        .qspi_cs_o       (qspi_cs_o),
        .qspi_io0_o      (qspi_io0_o),
        .qspi_io1_i      (qspi_io1_i),
        .qspi_io2_o      (qspi_io2_o),
        .qspi_io3_o      (qspi_io3_o),
        .mac_link_i      (mac_link_i),
        .rx_err_i        (rx_err_i),
        .eth_phy_rst_o   (eth_phy_rst_o),
        .eth_phy_mdc_o   (eth_phy_mdc_o),
        .eth_phy_mdio_io (eth_phy_mdio_io),
        .dbg_led_o       (dbg_led_o)
    );

    assign eth_phy_mdio_io = mdio_drive_en ? mdio_drive_val : 1'bz;

    always #20 reg_clk = ~reg_clk;

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic wait_clocks(input int n);
        repeat (n) @(posedge reg_clk);
        #2;     // inputs move just after the edge
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks_run++;
        if (actual !== expected) begin
            $display("Fail %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic start_case(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_case();
        $display("%s finished, %0d errors", cur_test, test_errors);
    endtask

    `include "board_ctrl_tests.svh"

    initial begin
        void'($urandom(seed));
        reg_clk        = 1'b0;
        rst_n_i        = 1'b0;
        spi_clk_i      = 1'b0;
        spi_cs_i       = 2'b11;
        spi_mosi_i     = 1'b0;
        qspi_io1_i     = 1'b1;
        mac_link_i     = 4'h0;
        rx_err_i       = 4'h0;
        mdio_drive_en  = 1'b0;
        mdio_drive_val = 1'b0;
        total_errors   = 0;
        tests_run      = 0;
        checks_run     = 0;
        repeat (reset_cycles) @(posedge reg_clk);
        #2;
        rst_n_i = 1'b1;

        reset_state();
        identity_and_status();
        test_regs_and_phy_reset();
        mdio_bitbang();
        error_counters();
        flash_and_led();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks_run, total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
